// File: include/adpcm_cfg.svh
// Single clock domain only; FIFO depth must stay at 4 entries or more for DATA back-pressure
`ifndef ADPCM_CFG_SVH
`define ADPCM_CFG_SVH

// Sample FIFO address width, 16 entries
`define ADPCM_FIFO_AW 4

// Wishbone word address width
`define ADPCM_WB_AW 2

// Register map, sized to ADPCM_WB_AW
`define ADPCM_REG_CTRL   2'd0
`define ADPCM_REG_HEADER 2'd1
`define ADPCM_REG_SAMPLE 2'd2 // DATA on write, SAMPLE on read
`define ADPCM_REG_STATUS 2'd3

`endif

// File: hw/adpcmPkg.sv
// Types only; the Wishbone address width comes from the config header
`include "adpcm_cfg.svh"

package adpcmPkg;

	typedef logic signed [15:0] sample_t; // Decoded audio sample
	typedef logic [15:0] rawWord_t;       // Four packed nibbles, lowest first
	typedef logic [3:0] shift_t;
	typedef logic [2:0] filter_t;
	typedef logic [1:0] nibblePos_t;

	// Master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`ADPCM_WB_AW-1:0] adr;
		logic [15:0] dat;
	} wbReq_t;

	// Slave to master
	typedef struct packed {
		logic ack;
		logic [15:0] dat;
	} wbRsp_t;

	// Accepted DATA word handed to the channel
	typedef struct packed {
		rawWord_t word;
		logic valid;
	} decodeJob_t;

	typedef enum logic {
		IDLE,
		DECODE
	} chanState_e;

endpackage

// File: hw/SDivTrunc.sv
// Combinational divide by 64 toward zero; OUTW must hold INW-6 bits or the top is lost
`timescale 1ns/1ps

module SDivTrunc #(
	parameter int INW  = 24,
	parameter int OUTW = 18
) (
	input  logic signed [INW-1:0]  valueIn,
	output logic signed [OUTW-1:0] valueOut
);

	logic signed [INW-1:0] biased;
	logic signed [INW-1:0] shifted;

	// Negative values get +63 so the arithmetic shift rounds toward zero
	assign biased = valueIn[INW-1] ? valueIn + INW'(63) : valueIn;
	assign shifted = biased >>> 6; // Sign kept
	assign valueOut = shifted[OUTW-1:0];

endmodule

// File: hw/clampSRange.sv
// Combinational signed saturation; INW must be larger than OUTW
`timescale 1ns/1ps

module clampSRange #(
	parameter int INW  = 19,
	parameter int OUTW = 16
) (
	input  logic signed [INW-1:0]  valueIn,
	output logic signed [OUTW-1:0] valueOut
);

	localparam logic signed [OUTW-1:0] MAX_VAL = {1'b0, {(OUTW-1){1'b1}}};
	localparam logic signed [OUTW-1:0] MIN_VAL = {1'b1, {(OUTW-1){1'b0}}};

	logic inRange;

	// Upper bits all equal means a plain sign extension
	assign inRange = (&valueIn[INW-1:OUTW-1]) || ~(|valueIn[INW-1:OUTW-1]);

	always_comb begin
		if (inRange)
			valueOut = valueIn[OUTW-1:0];
		else if (valueIn[INW-1])
			valueOut = MIN_VAL; // Negative overflow
		else
			valueOut = MAX_VAL;
	end

endmodule

// File: hw/ADPCMDecoder.sv
// Pure combinational nibble decode; caller registers the result and supplies the history
`timescale 1ns/1ps

module ADPCMDecoder (
	input  adpcmPkg::shift_t     i_Shift,
	input  adpcmPkg::filter_t    i_Filter,
	input  adpcmPkg::rawWord_t   i_inputRAW,
	input  adpcmPkg::nibblePos_t i_samplePosition,
	input  adpcmPkg::sample_t    i_PrevSample0, // Newest history
	input  adpcmPkg::sample_t    i_PrevSample1, // Older history
	output adpcmPkg::sample_t    o_sample
);

	import adpcmPkg::*;

	shift_t shiftEff;
	filter_t filterEff;
	logic [3:0] nibble;
	logic signed [6:0] stage1;
	sample_t baseSample;
	logic signed [7:0] weightPos;
	logic signed [7:0] weightNeg;
	logic signed [23:0] prodPos;
	logic signed [23:0] prodNeg;
	logic signed [23:0] predSum;
	logic signed [17:0] pred;
	logic signed [18:0] mixed;

	// Reserved shifts 13..15 behave as 9
	assign shiftEff = (i_Shift > 4'd12) ? 4'd9 : i_Shift;
	assign filterEff = (i_Filter > 3'd4) ? 3'd4 : i_Filter; // Only five filters

	always_comb begin
		case (filterEff)
			3'd1: begin
				weightPos = 8'sd60;
				weightNeg = 8'sd0;
			end
			3'd2: begin
				weightPos = 8'sd115;
				weightNeg = -8'sd52;
			end
			3'd3: begin
				weightPos = 8'sd98;
				weightNeg = -8'sd55;
			end
			3'd4: begin
				weightPos = 8'sd122;
				weightNeg = -8'sd60;
			end
			default: begin
				weightPos = 8'sd0; // Filter 0, no prediction
				weightNeg = 8'sd0;
			end
		endcase
	end

	assign nibble = i_inputRAW[{i_samplePosition, 2'b00} +: 4]; // Lowest nibble first

	// Nibble sits at bit 12, then shifted right; small stage first
	assign stage1 = $signed({nibble, 3'b000}) >>> shiftEff[1:0];
	assign baseSample = $signed({stage1, 9'b0}) >>> {shiftEff[3:2], 2'b00}; // Steps of 4

	// Prediction with rounding constant
	assign prodPos = i_PrevSample0 * weightPos;
	assign prodNeg = i_PrevSample1 * weightNeg;
	assign predSum = prodPos + prodNeg + 24'sd32; // Cannot overflow 24 bits with these weights

	SDivTrunc #(.INW(24), .OUTW(18)) uDiv64 (
		.valueIn (predSum),
		.valueOut(pred)
	);

	assign mixed = pred + baseSample; // 19 bits, room for the carry

	clampSRange #(.INW(19), .OUTW(16)) uClamp (
		.valueIn (mixed),
		.valueOut(o_sample)
	);

endmodule

// File: hw/adpcmChannel.sv
// One voice; a job is only legal while idle and the FIFO must already have 4 free entries
`timescale 1ns/1ps

module adpcmChannel (
	input  logic                 i_clk,
	input  logic                 i_rstN,
	input  adpcmPkg::decodeJob_t i_job,
	input  logic                 i_hdrWr,
	input  logic [7:0]           i_hdrByte,
	input  logic                 i_ctrlWr,
	input  logic [1:0]           i_ctrlBits,
	output logic                 o_busy,
	output logic                 o_push,
	output adpcmPkg::sample_t    o_sample
);

	import adpcmPkg::*;

	chanState_e state;
	nibblePos_t pos;
	rawWord_t word;
	shift_t shiftReg;
	filter_t filterReg;
	filter_t filterEff;
	logic xaMode;
	sample_t hist0; // Previous sample
	sample_t hist1; // Sample before that

	assign filterEff = xaMode ? {1'b0, filterReg[1:0]} : filterReg; // XA has four filters
	assign o_push = (state == DECODE);
	assign o_busy = (state == DECODE) || i_job.valid; // Job in flight counts too

	ADPCMDecoder uDecoder (
		.i_Shift         (shiftReg),
		.i_Filter        (filterEff),
		.i_inputRAW      (word),
		.i_samplePosition(pos),
		.i_PrevSample0   (hist0),
		.i_PrevSample1   (hist1),
		.o_sample        (o_sample)
	);

	// Sequencer, one nibble per clock
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			state <= IDLE;
			pos <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (i_job.valid) begin
						state <= DECODE;
						pos <= '0;
					end
				end
				DECODE: begin
					pos <= pos + 2'd1;
					if (pos == 2'd3)
						state <= IDLE; // Last nibble pushed
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_job.valid && state == IDLE)
			word <= i_job.word;
	end

	// Header, mode and history
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			shiftReg <= '0;
			filterReg <= '0;
			xaMode <= 1'b0;
			hist0 <= '0;
			hist1 <= '0;
		end else begin
			if (i_hdrWr) begin
				shiftReg <= i_hdrByte[3:0];
				filterReg <= i_hdrByte[6:4];
			end
			if (o_push) begin
				hist1 <= hist0; // Age the history
				hist0 <= o_sample;
			end
			if (i_ctrlWr) begin
				xaMode <= i_ctrlBits[0];
				if (i_ctrlBits[1]) begin
					hist0 <= '0; // Clear wins over a push
					hist1 <= '0;
				end
			end
		end
	end

	// Slave must hold DATA writes until the previous word is done
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_job.valid |-> state == IDLE);

endmodule

// File: hw/sampleFifo.sv
// Single clock FIFO; the writer and reader must respect the level, no overflow protection
`timescale 1ns/1ps
`include "adpcm_cfg.svh"

module sampleFifo (
	input  logic                     i_clk,
	input  logic                     i_rstN,
	input  logic                     i_push,
	input  adpcmPkg::sample_t        i_pushData,
	input  logic                     i_pop,
	output adpcmPkg::sample_t        o_head,
	output logic [`ADPCM_FIFO_AW:0]  o_level
);

	import adpcmPkg::*;

	localparam int AW = `ADPCM_FIFO_AW;
	localparam int DEPTH = 1 << AW;

	sample_t mem [DEPTH];
	logic [AW:0] wrPtr; // Extra bit tells full from empty
	logic [AW:0] rdPtr;

	assign o_level = wrPtr - rdPtr;
	assign o_head = mem[rdPtr[AW-1:0]]; // Head visible without latency

	always_ff @(posedge i_clk) begin
		if (i_push)
			mem[wrPtr[AW-1:0]] <= i_pushData;
	end

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (i_push)
				wrPtr <= wrPtr + 1'b1;
			if (i_pop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// Back-pressure in the slave keeps the channel from overrunning
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_push |-> o_level != (AW+1)'(DEPTH));
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_pop |-> o_level != '0);

endmodule

// File: hw/adpcmWbSlave.sv
// Wishbone classic only, no bursts or pipelining; master must drop stb for a cycle after ack
`timescale 1ns/1ps
`include "adpcm_cfg.svh"

module adpcmWbSlave (
	input  logic                     i_clk,
	input  logic                     i_rstN,
	input  adpcmPkg::wbReq_t         i_wb,
	output adpcmPkg::wbRsp_t         o_wb,
	output adpcmPkg::decodeJob_t     o_job,
	output logic                     o_hdrWr,
	output logic [7:0]               o_hdrByte,
	output logic                     o_ctrlWr,
	output logic [1:0]               o_ctrlBits,
	input  logic                     i_busy,
	output logic                     o_pop,
	input  adpcmPkg::sample_t        i_head,
	input  logic [`ADPCM_FIFO_AW:0]  i_level
);

	import adpcmPkg::*;

	localparam int LVL_W = `ADPCM_FIFO_AW + 1;
	localparam int DEPTH = 1 << `ADPCM_FIFO_AW;

	logic ackReg;
	logic [15:0] rdData;
	logic [15:0] rdMux;
	logic jobValid;
	rawWord_t jobWord;
	logic req;
	logic isSample;
	logic dataRoom;
	logic takeData;
	logic ackNext;

	assign req = i_wb.cyc && i_wb.stb && !ackReg; // New request, not the acked one
	assign isSample = (i_wb.adr == `ADPCM_REG_SAMPLE);
	assign dataRoom = !i_busy && (i_level <= LVL_W'(DEPTH - 4)); // Room for a whole word
	assign takeData = req && i_wb.we && isSample && dataRoom;
	assign ackNext = req && (!(i_wb.we && isSample) || dataRoom); // Stall held-off DATA
	assign o_pop = req && !i_wb.we && isSample && (i_level != '0); // Empty read pops nothing

	assign o_wb = '{ack: ackReg, dat: rdData};
	assign o_job = '{word: jobWord, valid: jobValid};

	// Read data select, writes return zero
	always_comb begin
		rdMux = '0;
		if (!i_wb.we) begin
			case (i_wb.adr)
				`ADPCM_REG_SAMPLE: rdMux = (i_level != '0) ? i_head : '0;
				`ADPCM_REG_STATUS: begin
					rdMux[LVL_W-1:0] = i_level;
					rdMux[8] = i_busy;
				end
				default: rdMux = '0; // CTRL and HEADER read as zero
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			ackReg <= 1'b0;
			jobValid <= 1'b0;
			o_hdrWr <= 1'b0;
			o_ctrlWr <= 1'b0;
		end else begin
			ackReg <= ackNext; // One cycle ack
			jobValid <= takeData;
			o_hdrWr <= req && i_wb.we && (i_wb.adr == `ADPCM_REG_HEADER);
			o_ctrlWr <= req && i_wb.we && (i_wb.adr == `ADPCM_REG_CTRL);
		end
	end

	// Payload alongside the pulses
	always_ff @(posedge i_clk) begin
		if (ackNext)
			rdData <= rdMux;
		if (takeData)
			jobWord <= i_wb.dat;
		if (req && i_wb.we && i_wb.adr == `ADPCM_REG_HEADER)
			o_hdrByte <= i_wb.dat[7:0];
		if (req && i_wb.we && i_wb.adr == `ADPCM_REG_CTRL)
			o_ctrlBits <= i_wb.dat[1:0];
	end

	// Master keeps its request up until it sees ack
	assert property (@(posedge i_clk) disable iff (!i_rstN)
		o_wb.ack |-> i_wb.cyc && i_wb.stb);

endmodule

// File: hw/adpcmCore.sv
// Single voice ADPCM decoder top; one clock, host reads samples back over the same port
`timescale 1ns/1ps
`include "adpcm_cfg.svh"

module adpcmCore (
	input  logic             i_clk,
	input  logic             i_rstN,
	input  adpcmPkg::wbReq_t i_wb,
	output adpcmPkg::wbRsp_t o_wb
);

	import adpcmPkg::*;

	decodeJob_t job;
	logic hdrWr;
	logic [7:0] hdrByte;
	logic ctrlWr;
	logic [1:0] ctrlBits;
	logic busy;
	logic push;
	logic pop;
	sample_t pushSample;
	sample_t head;
	logic [`ADPCM_FIFO_AW:0] level;

	adpcmWbSlave uSlave (
		.i_clk     (i_clk),
		.i_rstN    (i_rstN),
		.i_wb      (i_wb),
		.o_wb      (o_wb),
		.o_job     (job),
		.o_hdrWr   (hdrWr),
		.o_hdrByte (hdrByte),
		.o_ctrlWr  (ctrlWr),
		.o_ctrlBits(ctrlBits),
		.i_busy    (busy),
		.o_pop     (pop),
		.i_head    (head),
		.i_level   (level)
	);

	adpcmChannel uChannel (
		.i_clk     (i_clk),
		.i_rstN    (i_rstN),
		.i_job     (job),
		.i_hdrWr   (hdrWr),
		.i_hdrByte (hdrByte),
		.i_ctrlWr  (ctrlWr),
		.i_ctrlBits(ctrlBits),
		.o_busy    (busy),
		.o_push    (push),
		.o_sample  (pushSample)
	);

	// Samples wait here for the host
	sampleFifo uFifo (
		.i_clk     (i_clk),
		.i_rstN    (i_rstN),
		.i_push    (push),
		.i_pushData(pushSample),
		.i_pop     (pop),
		.o_head    (head),
		.o_level   (level)
	);

endmodule

// File: verification/tb_adpcmCore.sv
// Single Wishbone master, one bus cycle at a time; needs a simulator with timing and assertions
`timescale 1ns/1ps
`include "adpcm_cfg.svh"

module tb_adpcmCore;

	import adpcmPkg::*;

	localparam int ACK_TIMEOUT = 64;  // Cycles per bus cycle
	localparam int IDLE_TIMEOUT = 32; // STATUS polls
	localparam int POS_W [5] = '{0, 60, 115, 98, 122};
	localparam int NEG_W [5] = '{0, 0, -52, -55, -60};

	logic clk = 1'b0;
	logic rstN;
	wbReq_t wbReq;
	wbRsp_t wbRsp;

	// Model state of the channel
	shift_t mShift;
	filter_t mFilter;
	logic mXa;
	sample_t mH0;
	sample_t mH1;
	sample_t expQ [$]; // Expected samples in push order
	sample_t gotQ [$]; // Samples read back, waiting for compare
	sample_t cmpGot;
	sample_t cmpExp;

	adpcmCore DUT (
		.i_clk (clk),
		.i_rstN(rstN),
		.i_wb  (wbReq),
		.o_wb  (wbRsp)
	);

	always #4 clk = ~clk; // 8 ns period

	// Expected decode of one nibble from the header rules
	function automatic sample_t refDecode(input shift_t shift, input filter_t filter,
		input logic xa, input logic [3:0] nib, input sample_t h0, input sample_t h1);
		int s;
		int f;
		int base;
		int pred;
		int sum;
		s = (shift > 4'd12) ? 9 : int'(shift); // 13..15 act as 9
		f = xa ? int'(filter[1:0]) : int'(filter);
		if (f > 4)
			f = 4;
		base = int'($signed(nib)) * 4096;
		base = base >>> s;
		pred = (int'(h0) * POS_W[f] + int'(h1) * NEG_W[f] + 32) / 64; // Toward zero
		sum = pred + base;
		if (sum > 32767)
			sum = 32767;
		else if (sum < -32768)
			sum = -32768;
		return sample_t'(sum);
	endfunction

	task automatic checkEqual(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("FAIL time=%0t %s got %0d expected %0d", $time, name, got, exp);
			$display("Verification failed");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// One classic cycle; entered and left on a falling edge
	task automatic busCycle(input logic we, input logic [1:0] adr, input logic [15:0] dat,
		output logic [15:0] rdat);
		int waitCount;
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we = we;
		wbReq.adr = adr;
		wbReq.dat = dat;
		waitCount = 0;
		@(negedge clk);
		while (!wbRsp.ack) begin
			if (waitCount == ACK_TIMEOUT) begin
				$display("Timeout: no Wishbone ack at address %0d", adr);
				$display("Verification failed");
				$fatal(1, "Bus cycle timed out");
			end
			waitCount++;
			@(negedge clk);
		end
		rdat = wbRsp.dat;
		@(negedge clk); // Hold stb over the edge that samples ack
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
		wbReq.we = 1'b0;
		@(negedge clk); // Idle cycle between requests
	endtask

	task automatic writeCtrl(input logic xa, input logic clr);
		logic [15:0] rd;
		busCycle(1'b1, `ADPCM_REG_CTRL, {14'b0, clr, xa}, rd);
		mXa = xa;
		if (clr) begin
			mH0 = '0;
			mH1 = '0;
		end
	endtask

	task automatic writeHeader(input logic [7:0] hdr);
		logic [15:0] rd;
		busCycle(1'b1, `ADPCM_REG_HEADER, {8'b0, hdr}, rd);
		mShift = hdr[3:0];
		mFilter = hdr[6:4];
	endtask

	// DATA write, then four expected samples from the model
	task automatic sendWord(input rawWord_t w);
		logic [15:0] rd;
		sample_t e;
		busCycle(1'b1, `ADPCM_REG_SAMPLE, w, rd);
		for (int i = 0; i < 4; i++) begin
			e = refDecode(mShift, mFilter, mXa, w[i*4 +: 4], mH0, mH1);
			expQ.push_back(e);
			mH1 = mH0;
			mH0 = e;
		end
	endtask

	task automatic readSample(output sample_t v);
		logic [15:0] rd;
		busCycle(1'b0, `ADPCM_REG_SAMPLE, 16'h0, rd);
		v = sample_t'(rd);
		gotQ.push_back(v);
	endtask

	// Poll STATUS until the channel is idle
	task automatic waitIdle(output int level);
		logic [15:0] st;
		int tries;
		tries = 0;
		busCycle(1'b0, `ADPCM_REG_STATUS, 16'h0, st);
		while (st[8]) begin
			if (tries == IDLE_TIMEOUT) begin
				$display("Timeout: channel stayed busy");
				$display("Verification failed");
				$fatal(1, "Channel never went idle");
			end
			tries++;
			busCycle(1'b0, `ADPCM_REG_STATUS, 16'h0, st);
		end
		level = int'(st[4:0]);
	endtask

	task automatic drain();
		int lvl;
		sample_t v;
		waitIdle(lvl);
		checkEqual("STATUS level", lvl, expQ.size());
		repeat (lvl) readSample(v);
	endtask

	// DATA write that must stay unacked, then abandoned
	task automatic checkHeldOff(input rawWord_t w, input int cycles);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we = 1'b1;
		wbReq.adr = `ADPCM_REG_SAMPLE;
		wbReq.dat = w;
		repeat (cycles) begin
			@(negedge clk);
			assert (!wbRsp.ack) else begin
				$display("DATA write was acked while the FIFO was full");
				$display("Verification failed");
				$fatal(1, "Back-pressure broken");
			end
		end
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
		wbReq.we = 1'b0;
		@(negedge clk);
	endtask

	// Compare each read against the next expected sample
	always @(posedge clk) begin
		if (gotQ.size() != 0) begin
			cmpGot = gotQ.pop_front();
			if (expQ.size() == 0) begin
				$display("Sample read back with no expected sample left");
				$display("Verification failed");
				$fatal(1, "Unexpected sample");
			end
			cmpExp = expQ.pop_front();
			assert (cmpGot == cmpExp) else begin
				$display("FAIL time=%0t sample read data got %0d expected %0d",
					$time, cmpGot, cmpExp);
				$display("Verification failed");
				$fatal(1, "Sample mismatch");
			end
		end
	end

	initial begin
		int lvl;
		sample_t v;
		logic [15:0] rd;
		rawWord_t w;
		rawWord_t fifth;
		void'($urandom(32'hddb5a52a));
		rstN = 1'b0;
		wbReq = '0;
		mShift = '0;
		mFilter = '0;
		mXa = 1'b0;
		mH0 = '0;
		mH1 = '0;
		repeat (4) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		// Empty core after reset
		busCycle(1'b0, `ADPCM_REG_STATUS, 16'h0, rd);
		checkEqual("STATUS level", int'(rd[4:0]), 0);
		checkEqual("STATUS busy", int'(rd[8]), 0);
		busCycle(1'b0, `ADPCM_REG_SAMPLE, 16'h0, rd);
		checkEqual("empty SAMPLE read", int'(rd), 0);

		// Plain nibbles times 4096, lowest first
		writeCtrl(1'b0, 1'b1);
		writeHeader(8'h00);
		w = 16'h1F80;
		repeat (2) begin
			sendWord(w);
			waitIdle(lvl);
			checkEqual("STATUS level", lvl, 4);
			for (int i = 0; i < 4; i++) begin
				readSample(v);
				checkEqual("sample read data", int'(v), int'($signed(w[i*4 +: 4])) * 4096);
			end
			w = 16'h7654;
		end

		// Random SPU blocks, all shifts and filters
		for (int b = 0; b < 32; b++) begin
			writeHeader({1'($urandom()), 3'(b >> 2), 4'(b)});
			sendWord(16'($urandom()));
			sendWord(16'($urandom()));
			drain();
		end

		// XA mode ignores filter bit 2
		writeCtrl(1'b1, 1'b0);
		for (int f = 4; f < 8; f++) begin
			writeHeader({1'b0, 3'(f), 4'($urandom_range(12, 0))});
			sendWord(16'($urandom()));
			sendWord(16'($urandom()));
			drain();
		end
		writeCtrl(1'b1, 1'b1); // Decode again from zero history
		sendWord(16'($urandom()));
		drain();
		writeCtrl(1'b0, 1'b0);

		// Saturation at both ends
		writeCtrl(1'b0, 1'b1);
		writeHeader(8'h00);
		sendWord(16'h7777);
		drain();
		writeHeader(8'h10);
		sendWord(16'h7777);
		waitIdle(lvl);
		repeat (4) begin
			readSample(v);
			checkEqual("sample read data", int'(v), 32767);
		end
		writeHeader(8'h00);
		sendWord(16'h8888);
		drain();
		writeHeader(8'h40);
		sendWord(16'h8888);
		waitIdle(lvl);
		repeat (4) begin
			readSample(v);
			checkEqual("sample read data", int'(v), -32768);
		end

		// Back-pressure with a full FIFO
		writeCtrl(1'b0, 1'b1);
		writeHeader({1'b0, 3'($urandom()), 4'($urandom())});
		repeat (4) sendWord(16'($urandom()));
		waitIdle(lvl);
		checkEqual("STATUS level", lvl, 16);
		fifth = 16'($urandom());
		checkHeldOff(fifth, 20);
		busCycle(1'b0, `ADPCM_REG_STATUS, 16'h0, rd);
		checkEqual("STATUS level", int'(rd[4:0]), 16);
		repeat (4) readSample(v);
		sendWord(fifth); // Room for a word again
		drain();

		repeat (2) @(negedge clk);
		if (expQ.size() == 0 && gotQ.size() == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Samples left unchecked at the end of the run");
			$display("Verification failed");
			$fatal(1, "Queues not empty");
		end
	end

endmodule

// File: project.f
+incdir+include
hw/adpcmPkg.sv
hw/SDivTrunc.sv
hw/clampSRange.sv
hw/ADPCMDecoder.sv
hw/adpcmChannel.sv
hw/sampleFifo.sv
hw/adpcmWbSlave.sv
hw/adpcmCore.sv
verification/tb_adpcmCore.sv

// File: run.sh
#!/bin/sh
# Build and run the ADPCM core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_adpcmCore -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_adpcmCore > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0
